// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tbTop -f files.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tbChecker.sv ====
`timescale 1ns/100ps

module tbChecker (
    input logic                             M24,
    input logic                             arstN,
    input logic [7:0]                       romBank,
    input logic                             M12,
    input logic                             PE,
    input logic                             PQ,
    input logic                             irqN,
    input logic                             firqN,
    input logic                             nmiN,
    input logic                             cpuRstN,
    input logic [tileTimingPkg::H_BITS-1:0] pixelX,
    input logic [tileTimingPkg::V_BITS-1:0] rowY,
    input logic                             flipMode    // Flip the testbench has written
);
    import tileTimingPkg::*;

    localparam int LINE_CYCLES  = (H_LAST - H_START + 1) * 4;
    localparam int FRAME_CYCLES = LINE_CYCLES * (V_LAST - V_START + 1);
    localparam int INT_TIMEOUT  = FRAME_CYCLES + 2 * LINE_CYCLES;

    int errCount = 0;
    int testsRun = 0;
    int testsBad = 0;

    logic [3:0]        m12Hist, peHist, pqHist;    // Bit 0 is the previous sample
    logic [H_BITS-1:0] prevX, uX, nextX;
    logic [V_BITS-1:0] prevY, uY, nextY;
    logic [2:0]        prevAct;                    // {irq, firq, nmi} asserted
    int                sampleCnt;
    int                irqEntries;                 // Entries into row 496

    task automatic reportError(input string msg);
        errCount++;
        if (errCount <= 20) begin           // Only the first 20 are printed
            $display("ERROR %s", msg);
        end
    endtask

    task automatic expectValue(input string test, input string what,
                               input int expected, input int actual);
        if (expected != actual) begin
            errCount++;
            if (errCount <= 20) begin
                $display("FAIL %s %s expected %0h actual %0h", test, what, expected, actual);
            end
        end
    endtask

    // Bank value, interrupt state and a quiet frame after clearing all enables
    task automatic checkEntry(input string test, input logic [7:0] expBank,
                              input logic [2:0] expActive, input bit holdFrame);
        int errsBefore;
        int cycles;
        errsBefore = errCount;
        expectValue(test, "romBank", int'(expBank), int'(romBank));
        cycles = 0;
        while ({!irqN, !firqN, !nmiN} != expActive && cycles < INT_TIMEOUT) begin
            @(negedge M24);
            cycles++;
        end
        if ({!irqN, !firqN, !nmiN} != expActive) begin
            reportError($sformatf("%s: interrupts did not reach state %b, still at %b",
                                  test, expActive, {!irqN, !firqN, !nmiN}));
        end
        if (holdFrame) begin
            for (int i = 0; i < FRAME_CYCLES; i++) begin
                @(negedge M24);
                if (!irqN || !firqN || !nmiN) begin
                    reportError($sformatf("%s: interrupt asserted with enables clear", test));
                    break;
                end
            end
        end
        testsRun++;
        if (errCount == errsBefore) begin
            $display("ok   %s", test);
        end else begin
            testsBad++;
            $display("bad  %s (%0d errors)", test, errCount - errsBefore);
        end
    endtask

    always @(negedge M24) begin
        if (!arstN) begin
            sampleCnt  = 0;
            irqEntries = 0;
            prevAct    = 3'b000;
        end else begin
            sampleCnt++;
            if (sampleCnt > 8) begin            // History filled
                if (M12 == m12Hist[0]) reportError("M12 did not toggle");
                if (PQ == pqHist[3]) reportError("PQ period or duty cycle is wrong");
                if (PE == peHist[3]) reportError("PE period or duty cycle is wrong");
                if (PE != pqHist[1]) reportError("PE does not rise 2 cycles after PQ");
            end
            m12Hist = {m12Hist[2:0], M12};
            peHist  = {peHist[2:0], PE};
            pqHist  = {pqHist[2:0], PQ};

            uX = flipMode ? ~pixelX : pixelX;       // Back to counter order
            uY = flipMode ? ~rowY : rowY;
            if (sampleCnt > 2) begin
                nextX = (prevX == H_LAST) ? H_START : prevX + 9'd1;
                nextY = (prevY == V_LAST) ? V_START : prevY + 9'd1;
                if (uX != prevX && uX != nextX)
                    expectValue("scan", "pixelX", int'(flipMode ? ~nextX : nextX), int'(pixelX));
                if (uY != prevY && uY != nextY)
                    expectValue("scan", "rowY", int'(flipMode ? ~nextY : nextY), int'(rowY));
                if (uY != prevY && uY == V_IRQ_LINE) irqEntries++;
                // Fall row rules on the unflipped row
                if (!irqN && !prevAct[2] && uY != V_IRQ_LINE)
                    reportError($sformatf("irqN fell on row %0d", uY));
                if (!firqN && !prevAct[1] && !uY[0])
                    reportError($sformatf("firqN fell on even row %0d", uY));
                if (!nmiN && !prevAct[0] && (uY & NMI_LINE_MASK) != 9'd0)
                    reportError($sformatf("nmiN fell on row %0d", uY));
                if (cpuRstN != (irqEntries >= RST_FRAMES))
                    expectValue("delayed_reset", "cpuRstN",
                                int'(irqEntries >= RST_FRAMES), int'(cpuRstN));
            end
            prevX   = uX;
            prevY   = uY;
            prevAct = {!irqN, !firqN, !nmiN};
        end
    end

endmodule

// ==== dv/tbTop.sv ====
`timescale 1ns/100ps

module tbTop;
    import tileTimingPkg::*;
    import tileRegsPkg::*;

    localparam int NUM_TESTS  = 12;
    localparam int HS_TIMEOUT = 20;                            // Cycles per handshake phase
    localparam int LINE_CYCLES  = (H_LAST - H_START + 1) * 4;
    localparam int FRAME_CYCLES = LINE_CYCLES * (V_LAST - V_START + 1);
    localparam int RST_TIMEOUT  = FRAME_CYCLES * (RST_FRAMES + 2);

    typedef struct {
        string           name;
        logic [15:0]     addr;
        logic [7:0]      data;
        bit              randData;     // Replace data with a random byte
        logic [7:0]      expBank;
        logic [2:0]      expActive;    // {irq, firq, nmi}, 1 means asserted
        bit              expFlip;
    } entry_t;

    logic                 M24;
    logic                 arstN;
    logic                 wrReq;
    logic [ADDR_BITS-1:0] wrAddr;
    logic [DATA_BITS-1:0] wrData;
    logic                 wrAck;
    logic [DATA_BITS-1:0] romBank;
    logic                 M12, PE, PQ;
    logic                 irqN, firqN, nmiN, cpuRstN;
    logic [H_BITS-1:0]    pixelX;
    logic [V_BITS-1:0]    rowY;
    logic                 flipMode;     // Flip state the checker assumes

    entry_t tests[NUM_TESTS];

    k052109Top UUT (
        .M24     (M24),
        .arstN   (arstN),
        .wrReq   (wrReq),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .wrAck   (wrAck),
        .romBank (romBank),
        .M12     (M12),
        .PE      (PE),
        .PQ      (PQ),
        .irqN    (irqN),
        .firqN   (firqN),
        .nmiN    (nmiN),
        .cpuRstN (cpuRstN),
        .pixelX  (pixelX),
        .rowY    (rowY)
    );

    tbChecker monitor (
        .M24      (M24),
        .arstN    (arstN),
        .romBank  (romBank),
        .M12      (M12),
        .PE       (PE),
        .PQ       (PQ),
        .irqN     (irqN),
        .firqN    (firqN),
        .nmiN     (nmiN),
        .cpuRstN  (cpuRstN),
        .pixelX   (pixelX),
        .rowY     (rowY),
        .flipMode (flipMode)
    );

    initial begin
        M24 = 1'b0;
        forever #5 M24 = ~M24;      // 10 ns period
    end

    function automatic void addTest(input int idx, input string name, input logic [15:0] addr,
                                    input logic [7:0] data, input bit rnd, input logic [7:0] bank,
                                    input logic [2:0] act, input bit fl);
        tests[idx] = '{name, addr, data, rnd, bank, act, fl};
    endfunction

    // Name, address, data, random data, bank, asserted interrupts, flip
    function automatic void fillTable();
        addTest(0,  "bank_a5",     16'h1D80, 8'hA5, 1'b0, 8'hA5, 3'b000, 1'b0);
        addTest(1,  "scroll_1C00", 16'h1C00, 8'h00, 1'b1, 8'hA5, 3'b000, 1'b0);
        addTest(2,  "scroll_1E00", 16'h1E00, 8'h00, 1'b1, 8'hA5, 3'b000, 1'b0);
        addTest(3,  "bank_3c",     16'h1D80, 8'h3C, 1'b0, 8'h3C, 3'b000, 1'b0);
        addTest(4,  "nmi_firq_on", 16'h1D00, 8'h03, 1'b0, 8'h3C, 3'b011, 1'b0);
        addTest(5,  "irq_on",      16'h1D00, 8'h07, 1'b0, 8'h3C, 3'b111, 1'b0);
        addTest(6,  "flip_on",     16'h1E80, 8'h01, 1'b0, 8'h3C, 3'b111, 1'b1);
        addTest(7,  "scroll_1F00", 16'h1F00, 8'h00, 1'b1, 8'h3C, 3'b111, 1'b1);
        addTest(8,  "ints_off",    16'h1D00, 8'h00, 1'b0, 8'h3C, 3'b000, 1'b1);
        addTest(9,  "irq_on_flip", 16'h1D00, 8'h04, 1'b0, 8'h3C, 3'b100, 1'b1);
        addTest(10, "flip_off",    16'h1E80, 8'h00, 1'b0, 8'h3C, 3'b100, 1'b0);
        addTest(11, "ints_off_2",  16'h1D00, 8'h00, 1'b0, 8'h3C, 3'b000, 1'b0);
    endfunction

    // One four-phase write, then the checks of the entry
    task automatic runEntry(input entry_t t);
        logic [7:0] data;
        int         cycles;
        data = t.randData ? 8'($urandom) : t.data;
        repeat ($urandom_range(8, 1)) @(posedge M24);     // Random idle gap
        wrAddr <= t.addr;
        wrData <= data;
        wrReq  <= 1'b1;
        cycles = 0;
        do begin
            @(negedge M24);
            cycles++;
        end while (!wrAck && cycles < HS_TIMEOUT);
        if (!wrAck) begin
            monitor.reportError($sformatf("%s: wrAck never rose after wrReq", t.name));
        end else begin
            monitor.expectValue(t.name, "wrAck latency", 1, cycles - 1);
        end
        flipMode <= t.expFlip;
        @(posedge M24);
        wrReq <= 1'b0;
        cycles = 0;
        do begin
            @(negedge M24);
            cycles++;
        end while (wrAck && cycles < HS_TIMEOUT);
        if (wrAck) begin
            monitor.reportError($sformatf("%s: wrAck stayed high after wrReq fell", t.name));
        end
        monitor.checkEntry(t.name, t.expBank, t.expActive,
                           (t.addr == REG_IRQ_EN) && (data[2:0] == 3'b000));
    endtask

    initial begin
        int cycles;
        void'($urandom(92844));
        arstN    = 1'b0;
        wrReq    = 1'b0;
        wrAddr   = '0;
        wrData   = '0;
        flipMode = 1'b0;
        fillTable();
        repeat (3) @(posedge M24);
        arstN <= 1'b1;
        @(negedge M24);
        monitor.expectValue("reset", "cpuRstN", 0, int'(cpuRstN));
        for (int i = 0; i < NUM_TESTS; i++) begin
            runEntry(tests[i]);
        end
        cycles = 0;
        while (!cpuRstN && cycles < RST_TIMEOUT) begin    // Delayed CPU reset release
            @(negedge M24);
            cycles++;
        end
        if (!cpuRstN) begin
            monitor.reportError("cpuRstN never released after eight frames");
        end
        $display("Tests %0d, failed %0d, errors %0d",
                 monitor.testsRun, monitor.testsBad, monitor.errCount);
        if (monitor.errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
verilog/tileTimingPkg.sv
verilog/tileRegsPkg.sv
verilog/cpuClockGen.sv
verilog/videoTiming.sv
verilog/registerFile.sv
verilog/scanOutputControl.sv
verilog/k052109Top.sv
dv/tbChecker.sv
dv/tbTop.sv

// ==== verilog/cpuClockGen.sv ====
`timescale 1ns/100ps

module cpuClockGen (
    input  logic M24,         // 24 MHz master clock
    input  logic arstN,
    output logic M12,         // CPU clock, M24 / 2
    output logic PE,          // 6809 E clock
    output logic PQ,          // 6809 Q clock, leads E by a quarter period
    output logic pixelStb     // Pixel enable, one M24 cycle in four
);
    import tileTimingPkg::*;

    logic [PHASE_BITS-1:0] phase;        // Position in 8-cycle E period
    logic [PHASE_BITS-1:0] phaseNext;

    assign phaseNext = phase + 1'b1;     // Free running, wraps at 8

    // Outputs decoded from the next phase so they come straight off flops
    // and line up with the phase register
    always_ff @(posedge M24 or negedge arstN) begin
        if (!arstN) begin
            phase    <= '0;
            M12      <= 1'b0;
            PE       <= 1'b0;
            PQ       <= 1'b0;
            pixelStb <= 1'b0;
        end else begin
            phase    <= phaseNext;
            M12      <= phaseNext[0];                   // Toggles every cycle
            PQ       <= phaseNext[2] ^ phaseNext[1];    // High in phases 2 to 5
            PE       <= phaseNext[2];                   // High in phases 4 to 7
            pixelStb <= &phaseNext[1:0];                // Phases 3 and 7
        end
    end

endmodule

// ==== verilog/k052109Top.sv ====
`timescale 1ns/100ps

module k052109Top (
    input  logic                                M24,
    input  logic                                arstN,
    // CPU write port
    input  logic                                wrReq,
    input  logic [tileRegsPkg::ADDR_BITS-1:0]   wrAddr,
    input  logic [tileRegsPkg::DATA_BITS-1:0]   wrData,
    output logic                                wrAck,
    output logic [tileRegsPkg::DATA_BITS-1:0]   romBank,
    // CPU clocks and control
    output logic                                M12,
    output logic                                PE,
    output logic                                PQ,
    output logic                                irqN,
    output logic                                firqN,
    output logic                                nmiN,
    output logic                                cpuRstN,
    // Screen position
    output logic [tileTimingPkg::H_BITS-1:0]    pixelX,
    output logic [tileTimingPkg::V_BITS-1:0]    rowY
);
    import tileTimingPkg::*;

    logic              pixelStb;
    logic [H_BITS-1:0] hCount;
    logic [V_BITS-1:0] vCount;
    logic              lineStart;
    logic              frameStart;
    logic [2:0]        irqEn;
    logic              flip;

    cpuClockGen clockGen (
        .M24      (M24),
        .arstN    (arstN),
        .M12      (M12),
        .PE       (PE),
        .PQ       (PQ),
        .pixelStb (pixelStb)
    );

    videoTiming timing (
        .M24        (M24),
        .arstN      (arstN),
        .pixelStb   (pixelStb),
        .hCount     (hCount),
        .vCount     (vCount),
        .lineStart  (lineStart),
        .frameStart (frameStart)
    );

    registerFile regs (
        .M24     (M24),
        .arstN   (arstN),
        .wrReq   (wrReq),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .wrAck   (wrAck),
        .irqEn   (irqEn),
        .romBank (romBank),
        .flip    (flip)
    );

    scanOutputControl scanCtrl (
        .M24        (M24),
        .arstN      (arstN),
        .hCount     (hCount),
        .vCount     (vCount),
        .lineStart  (lineStart),
        .frameStart (frameStart),
        .irqEn      (irqEn),
        .flip       (flip),
        .pixelX     (pixelX),
        .rowY       (rowY),
        .irqN       (irqN),
        .firqN      (firqN),
        .nmiN       (nmiN),
        .cpuRstN    (cpuRstN)
    );

endmodule

// ==== verilog/registerFile.sv ====
`timescale 1ns/100ps

module registerFile (
    input  logic                                M24,
    input  logic                                arstN,
    input  logic                                wrReq,      // CPU write request
    input  logic [tileRegsPkg::ADDR_BITS-1:0]   wrAddr,     // Held stable while wrReq
    input  logic [tileRegsPkg::DATA_BITS-1:0]   wrData,     // Held stable while wrReq
    output logic                                wrAck,      // Write taken
    output logic [2:0]                          irqEn,      // Indexed by EN_NMI/FIRQ/IRQ
    output logic [tileRegsPkg::DATA_BITS-1:0]   romBank,    // Bank for GFX ROM reads
    output logic                                flip        // Screen flip
);
    import tileRegsPkg::*;

    logic wrStb;       // New request, one cycle
    logic selIrqEn;
    logic selRomBank;
    logic selFlip;

    // Request seen while ack is low starts a write
    assign wrStb = wrReq && !wrAck;

    // Full address compare, scroll and test addresses match nothing
    assign selIrqEn   = (wrAddr == REG_IRQ_EN);
    assign selRomBank = (wrAddr == REG_ROM_BANK);
    assign selFlip    = (wrAddr == REG_FLIP);

    // Four-phase handshake
    always_ff @(posedge M24 or negedge arstN) begin
        if (!arstN) begin
            wrAck <= 1'b0;
        end else if (wrStb) begin
            wrAck <= 1'b1;                  // Same edge as register load
        end else if (!wrReq) begin
            wrAck <= 1'b0;                  // Drop once CPU has released
        end
    end

    // Control registers
    always_ff @(posedge M24 or negedge arstN) begin
        if (!arstN) begin
            irqEn   <= '0;
            romBank <= '0;
            flip    <= 1'b0;
        end else if (wrStb) begin
            if (selIrqEn) begin
                irqEn[EN_NMI]  <= wrData[EN_NMI];
                irqEn[EN_FIRQ] <= wrData[EN_FIRQ];
                irqEn[EN_IRQ]  <= wrData[EN_IRQ];
            end
            if (selRomBank) begin
                romBank <= wrData;          // Whole byte kept
            end
            if (selFlip) begin
                flip <= wrData[FLIP_BIT];
            end
        end
    end

endmodule

// ==== verilog/scanOutputControl.sv ====
`timescale 1ns/100ps

module scanOutputControl (
    input  logic                              M24,
    input  logic                              arstN,
    input  logic [tileTimingPkg::H_BITS-1:0]  hCount,
    input  logic [tileTimingPkg::V_BITS-1:0]  vCount,
    input  logic                              lineStart,
    input  logic                              frameStart,
    input  logic [2:0]                        irqEn,      // Indexed by EN_NMI/FIRQ/IRQ
    input  logic                              flip,
    output logic [tileTimingPkg::H_BITS-1:0]  pixelX,     // Screen position, flip applied
    output logic [tileTimingPkg::V_BITS-1:0]  rowY,
    output logic                              irqN,
    output logic                              firqN,
    output logic                              nmiN,
    output logic                              cpuRstN     // Delayed CPU reset
);
    import tileTimingPkg::*;
    import tileRegsPkg::*;

    localparam int RST_CNT_BITS = $clog2(RST_FRAMES + 1);

    logic [2:0]              trig;        // Line events indexed like irqEn
    logic [2:0]              intN;        // Active-low interrupt latches
    logic [RST_CNT_BITS-1:0] frameCnt;    // IRQ lines seen since reset

    // Flip inverts every bit, so 128..511 maps to 383..0
    always_ff @(posedge M24) begin
        pixelX <= flip ? ~hCount : hCount;
        rowY   <= flip ? ~vCount : vCount;
    end

    // Trigger lines come from the unflipped counter
    assign trig[EN_IRQ]  = lineStart && (vCount == V_IRQ_LINE);        // Once per frame
    assign trig[EN_FIRQ] = lineStart && vCount[0];                      // Odd lines
    assign trig[EN_NMI]  = lineStart && ((vCount & NMI_LINE_MASK) == '0);

    // Latch sets on trigger and is held clear while enable is low
    always_ff @(posedge M24 or negedge arstN) begin
        if (!arstN) begin
            intN <= '1;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (!irqEn[i]) begin
                    intN[i] <= 1'b1;        // Acknowledge by clearing enable
                end else if (trig[i]) begin
                    intN[i] <= 1'b0;
                end
            end
        end
    end

    assign irqN  = intN[EN_IRQ];
    assign firqN = intN[EN_FIRQ];
    assign nmiN  = intN[EN_NMI];

    // CPU reset release after RST_FRAMES IRQ line starts
    always_ff @(posedge M24 or negedge arstN) begin
        if (!arstN) begin
            frameCnt <= '0;
            cpuRstN  <= 1'b0;
        end else if (trig[EN_IRQ] && !cpuRstN) begin
            frameCnt <= frameCnt + 1'b1;
            if (frameCnt == RST_CNT_BITS'(RST_FRAMES - 1)) begin
                cpuRstN <= 1'b1;            // Stays high until next reset
            end
        end
    end

endmodule

// ==== verilog/tileRegsPkg.sv ====
package tileRegsPkg;

    // CPU bus widths
    localparam int ADDR_BITS = 16;
    localparam int DATA_BITS = 8;

    // Control register addresses, full decode
    localparam logic [ADDR_BITS-1:0] REG_IRQ_EN   = 16'h1D00;    // Interrupt enables
    localparam logic [ADDR_BITS-1:0] REG_ROM_BANK = 16'h1D80;    // ROM bank select
    localparam logic [ADDR_BITS-1:0] REG_FLIP     = 16'h1E80;    // Screen flip

    // Bit positions in the interrupt enable register
    // Also index the irqEn vector directly
    localparam int EN_NMI  = 0;
    localparam int EN_FIRQ = 1;
    localparam int EN_IRQ  = 2;

    // Bit position in the flip register
    localparam int FLIP_BIT = 0;

endpackage

// ==== verilog/tileTimingPkg.sv ====
package tileTimingPkg;

    // Scan counter widths
    localparam int H_BITS = 9;
    localparam int V_BITS = 9;

    // Horizontal scan, 384 pixels per line
    localparam logic [H_BITS-1:0] H_START = 9'd128;    // First pixel after reload
    localparam logic [H_BITS-1:0] H_LAST  = 9'd511;    // Last pixel before reload

    // Vertical scan, 264 lines per frame
    localparam logic [V_BITS-1:0] V_START = 9'd248;    // First line after reload
    localparam logic [V_BITS-1:0] V_LAST  = 9'd511;    // Last line before reload

    // Line where vertical blank begins and IRQ fires
    localparam logic [V_BITS-1:0] V_IRQ_LINE = 9'd496;

    // NMI fires every 32 lines
    localparam logic [V_BITS-1:0] NMI_LINE_MASK = 9'h01F;

    // CPU reset held over this many IRQ lines
    localparam int RST_FRAMES = 8;

    // CPU clock phase counter, 8 M24 cycles per E period
    localparam int PHASE_BITS = 3;

endpackage

// ==== verilog/videoTiming.sv ====
`timescale 1ns/100ps

module videoTiming (
    input  logic                              M24,
    input  logic                              arstN,
    input  logic                              pixelStb,      // Advance one pixel
    output logic [tileTimingPkg::H_BITS-1:0]  hCount,        // Pixel within line
    output logic [tileTimingPkg::V_BITS-1:0]  vCount,        // Line within frame
    output logic                              lineStart,     // First cycle of new line
    output logic                              frameStart     // First cycle of new frame
);
    import tileTimingPkg::*;

    logic lineEnd;     // Last pixel of line is being left
    logic frameEnd;    // Last line of frame is being left

    assign lineEnd  = pixelStb && (hCount == H_LAST);
    assign frameEnd = lineEnd && (vCount == V_LAST);

    // Pixel counter
    always_ff @(posedge M24 or negedge arstN) begin
        if (!arstN) begin
            hCount    <= H_START;
            lineStart <= 1'b0;
        end else begin
            lineStart <= lineEnd;               // High while hCount shows H_START
            if (lineEnd) begin
                hCount <= H_START;              // Reload, skips H blank range
            end else if (pixelStb) begin
                hCount <= hCount + 1'b1;
            end
        end
    end

    // Line counter, steps together with the pixel wrap
    always_ff @(posedge M24 or negedge arstN) begin
        if (!arstN) begin
            vCount     <= V_START;
            frameStart <= 1'b0;
        end else begin
            frameStart <= frameEnd;             // Coincides with lineStart
            if (frameEnd) begin
                vCount <= V_START;              // Reload at top of frame
            end else if (lineEnd) begin
                vCount <= vCount + 1'b1;
            end
        end
    end

endmodule
